// ==== hw/m6502_pkg.sv ====
`default_nettype none

package m6502_pkg;

   // Operand addressing of one instruction.
   typedef enum logic [3:0] {
      mode_none,
      mode_reset,  // Vector fetch at FFFC/FFFD.
      mode_imm,
      mode_zp,
      mode_zp_x,
      mode_zp_y,
      mode_abs,
      mode_abs_x,
      mode_abs_y,
      mode_ind_x,
      mode_ind_y
   } addr_mode_t;

   typedef enum logic [2:0] {
      op_nop,
      op_load_a,
      op_load_x,
      op_load_y,
      op_store_a,
      op_jump
   } mem_op_t;

   typedef struct packed {
      mem_op_t    op;
      addr_mode_t mode;
      logic [1:0] length;  // Instruction bytes, opcode included.
   } decode_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        wr_en;
      logic        rd_req;
   } mem_req_t;

   typedef struct packed {
      logic       valid;
      logic [7:0] index;  // Low address byte of the store.
      logic [7:0] data;
   } out_evt_t;

   localparam logic [15:0] reset_vector = 16'hfffc;
   localparam logic [7:0]  out_page     = 8'hd0;

endpackage

`default_nettype wire

// ==== hw/m6502_decode.sv ====
`default_nettype none

module m6502_decode (
   input  logic [7:0]          opcode,
   output m6502_pkg::decode_t  dec
);
   import m6502_pkg::*;

   // The bbb field of group-one opcodes (aaabbb01).
   function automatic addr_mode_t group_one_mode(input logic [2:0] bbb);
      addr_mode_t m;
      case (bbb)
         3'd0: m = mode_ind_x;
         3'd1: m = mode_zp;
         3'd2: m = mode_imm;
         3'd3: m = mode_abs;
         3'd4: m = mode_ind_y;
         3'd5: m = mode_zp_x;
         3'd6: m = mode_abs_y;
         default: m = mode_abs_x;
      endcase
      return m;
   endfunction

   always_comb
   begin
      dec = '{op: op_nop, mode: mode_none, length: 2'd1};
      if (opcode[1:0] == 2'b01 && opcode[7:5] == 3'b101)
      begin
         dec.op   = op_load_a;
         dec.mode = group_one_mode(opcode[4:2]);
      end
      else if (opcode[1:0] == 2'b01 && opcode[7:5] == 3'b100 && opcode[4:2] != 3'd2)
      begin
         dec.op   = op_store_a;  // No immediate store.
         dec.mode = group_one_mode(opcode[4:2]);
      end
      else
      begin
         case (opcode)
            8'ha0: dec = '{op: op_load_y, mode: mode_imm, length: 2'd1};
            8'ha4: dec = '{op: op_load_y, mode: mode_zp, length: 2'd1};
            8'hac: dec = '{op: op_load_y, mode: mode_abs, length: 2'd1};
            8'ha2: dec = '{op: op_load_x, mode: mode_imm, length: 2'd1};
            8'ha6: dec = '{op: op_load_x, mode: mode_zp, length: 2'd1};
            8'hae: dec = '{op: op_load_x, mode: mode_abs, length: 2'd1};
            8'h4c: dec = '{op: op_jump, mode: mode_abs, length: 2'd1};
            default: ;  // Skipped as a one-byte nop.
         endcase
      end

      case (dec.mode)
         mode_imm, mode_zp, mode_zp_x, mode_zp_y, mode_ind_x, mode_ind_y:
            dec.length = 2'd2;
         mode_abs, mode_abs_x, mode_abs_y:
            dec.length = 2'd3;
         default:
            dec.length = 2'd1;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/m6502_agu.sv ====
`default_nettype none

module m6502_agu (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                start,
   input  m6502_pkg::decode_t  dec,
   input  logic [15:0]         pc,
   input  logic [7:0]          x,
   input  logic [7:0]          y,
   input  logic [7:0]          rd_data,
   input  logic                ready,
   output m6502_pkg::mem_req_t mem_req,
   output logic [7:0]          operand,
   output logic [15:0]         target,
   output logic                done
);
   import m6502_pkg::*;

   typedef enum logic [2:0] {s_idle, s_lo, s_hi, s_ptr_lo, s_ptr_hi, s_data} agu_state_t;

   agu_state_t  state;
   mem_op_t     op;
   addr_mode_t  mode;
   logic [15:0] rd_addr;
   logic        rd_req;
   logic [7:0]  lo;
   logic [7:0]  zp_idx;
   logic [7:0]  abs_idx;
   logic [7:0]  zp_sum;
   logic [15:0] abs_sum;
   logic [15:0] ea;
   logic        at_ea;
   logic        is_load;

   assign mem_req = '{addr: rd_addr, wr_data: 8'h00, wr_en: 1'b0, rd_req: rd_req};

   // X is a pre-index for (zp,X); Y is a post-index for (zp),Y.
   assign zp_idx  = (mode == mode_zp_x || mode == mode_ind_x) ? x :
                    (mode == mode_zp_y) ? y : 8'h00;
   assign abs_idx = (mode == mode_abs_x) ? x :
                    (mode == mode_abs_y || mode == mode_ind_y) ? y : 8'h00;

   assign zp_sum  = rd_data + zp_idx;  // Wraps inside page 0.
   assign abs_sum = {rd_data, lo} + {8'h00, abs_idx};
   assign ea      = (state == s_lo) ? {8'h00, zp_sum} : abs_sum;
   assign is_load = (op == op_load_a || op == op_load_x || op == op_load_y);

   // The effective address is complete on this ready.
   assign at_ea = ready && ((state == s_hi) || (state == s_ptr_hi) ||
                  (state == s_lo && (mode == mode_zp || mode == mode_zp_x ||
                                     mode == mode_zp_y)));

   always_ff @(posedge clk)
   begin
      rd_req <= 1'b0;
      done   <= 1'b0;
      if (!reset_n)
      begin
         state <= s_idle;
      end
      else
      begin
         case (state)
            s_idle:
               if (start)
               begin
                  op   <= dec.op;
                  mode <= dec.mode;
                  if (dec.mode == mode_none)
                  begin
                     done <= 1'b1;
                  end
                  else
                  begin
                     rd_addr <= (dec.mode == mode_reset) ? reset_vector : pc + 16'd1;
                     rd_req  <= 1'b1;
                     state   <= s_lo;
                  end
               end
            s_lo:
               if (ready)
               begin
                  lo <= rd_data;
                  case (mode)
                     mode_imm:
                     begin
                        operand <= rd_data;
                        done    <= 1'b1;
                        state   <= s_idle;
                     end
                     mode_zp, mode_zp_x, mode_zp_y: ;
                     mode_ind_x, mode_ind_y:
                     begin
                        rd_addr <= {8'h00, zp_sum};  // Pointer low byte.
                        rd_req  <= 1'b1;
                        state   <= s_ptr_lo;
                     end
                     default:
                     begin
                        rd_addr <= rd_addr + 16'd1;
                        rd_req  <= 1'b1;
                        state   <= s_hi;
                     end
                  endcase
               end
            s_ptr_lo:
               if (ready)
               begin
                  lo      <= rd_data;
                  rd_addr <= {8'h00, rd_addr[7:0] + 8'd1};
                  rd_req  <= 1'b1;
                  state   <= s_ptr_hi;
               end
            s_data:
               if (ready)
               begin
                  operand <= rd_data;
                  done    <= 1'b1;
                  state   <= s_idle;
               end
            default: ;
         endcase

         if (at_ea)
         begin
            if (is_load)
            begin
               rd_addr <= ea;
               rd_req  <= 1'b1;
               state   <= s_data;
            end
            else
            begin
               target <= ea;
               done   <= 1'b1;
               state  <= s_idle;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/m6502_cpu.sv ====
`default_nettype none

module m6502_cpu (
   input  logic                clk,
   input  logic                reset_n,
   output m6502_pkg::mem_req_t mem_req,
   input  logic [7:0]          rd_data,
   input  logic                ready
);
   import m6502_pkg::*;

   typedef enum logic [2:0] {
      st_reset, st_fetch, st_load_inst, st_execute, st_execute_wait
   } cpu_state_t;

   localparam decode_t vector_dec = '{op: op_jump, mode: mode_reset, length: 2'd0};

   cpu_state_t  state;
   logic        booting;  // Vector fetch still pending.
   logic [15:0] pc;
   logic [7:0]  ir;
   logic [7:0]  a;
   logic [7:0]  x;
   logic [7:0]  y;
   decode_t     dec;
   decode_t     agu_dec;
   logic        agu_start;
   logic        agu_done;
   logic [7:0]  operand;
   logic [15:0] target;
   mem_req_t    cpu_req;
   mem_req_t    agu_req;

   m6502_decode i_m6502_decode (
      .opcode (ir),
      .dec    (dec)
   );

   assign agu_dec   = booting ? vector_dec : dec;
   assign agu_start = (state == st_reset) || (state == st_execute);

   m6502_agu i_m6502_agu (
      .clk     (clk),
      .reset_n (reset_n),
      .start   (agu_start),
      .dec     (agu_dec),
      .pc      (pc),
      .x       (x),
      .y       (y),
      .rd_data (rd_data),
      .ready   (ready),
      .mem_req (agu_req),
      .operand (operand),
      .target  (target),
      .done    (agu_done)
   );

   assign mem_req = (state == st_execute_wait) ? agu_req : cpu_req;

   always_ff @(posedge clk)
   begin
      cpu_req.rd_req <= 1'b0;
      cpu_req.wr_en  <= 1'b0;
      if (!reset_n)
      begin
         state   <= st_reset;
         booting <= 1'b1;
         a       <= 8'h00;
         x       <= 8'h00;
         y       <= 8'h00;
      end
      else
      begin
         case (state)
            st_reset:
               state <= st_execute_wait;
            st_fetch:
            begin
               cpu_req.addr   <= pc;
               cpu_req.rd_req <= 1'b1;
               state          <= st_load_inst;
            end
            st_load_inst:
               if (ready)
               begin
                  ir    <= rd_data;
                  state <= st_execute;
               end
            st_execute:
               state <= st_execute_wait;  // Decode cycle.
            st_execute_wait:
               if (agu_done)
               begin
                  booting <= 1'b0;
                  state   <= st_fetch;
                  if (booting || dec.op == op_jump)
                     pc <= target;
                  else
                     pc <= pc + {14'd0, dec.length};
                  if (!booting)
                  begin
                     case (dec.op)
                        op_load_a: a <= operand;
                        op_load_x: x <= operand;
                        op_load_y: y <= operand;
                        op_store_a:
                        begin
                           cpu_req.addr    <= target;
                           cpu_req.wr_data <= a;
                           cpu_req.wr_en   <= 1'b1;
                        end
                        default: ;
                     endcase
                  end
               end
            default:
               state <= st_reset;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/m6502_ram.sv ====
`default_nettype none

module m6502_ram #(
   parameter int ram_addr_bits = 12
) (
   input  logic                clk,
   input  m6502_pkg::mem_req_t req,
   input  logic                host_wr,
   input  logic [15:0]         host_addr,
   input  logic [7:0]          host_data,
   output logic [7:0]          rd_data,
   output logic                ready
);

   logic [7:0] mem [2**ram_addr_bits];

   // Host loader wins over the CPU.
   always_ff @(posedge clk)
   begin
      if (host_wr)
         mem[host_addr[ram_addr_bits-1:0]] <= host_data;
      else if (req.wr_en)
         mem[req.addr[ram_addr_bits-1:0]] <= req.wr_data;
   end

   always_ff @(posedge clk)
   begin
      ready <= req.rd_req;  // One cycle read latency.
      if (req.rd_req)
         rd_data <= mem[req.addr[ram_addr_bits-1:0]];
   end

endmodule

`default_nettype wire

// ==== hw/m6502_out_port.sv ====
`default_nettype none

module m6502_out_port #(
   parameter int ram_addr_bits = 12
) (
   input  logic                clk,
   input  logic                reset_n,
   input  m6502_pkg::mem_req_t cpu_req,
   output m6502_pkg::mem_req_t ram_req,
   output m6502_pkg::out_evt_t out_evt
);
   import m6502_pkg::*;

   localparam logic [15:0] addr_mask = 16'((32'd1 << ram_addr_bits) - 1);

   logic out_hit;

   assign out_hit = cpu_req.wr_en && (cpu_req.addr[15:8] == out_page);

   always_comb
   begin
      ram_req       = cpu_req;
      ram_req.addr  = cpu_req.addr & addr_mask;  // Wraps modulo RAM size.
      ram_req.wr_en = cpu_req.wr_en && !out_hit;
   end

   always_ff @(posedge clk)
   begin
      out_evt.valid <= 1'b0;
      if (!reset_n)
      begin
         out_evt.valid <= 1'b0;
      end
      else if (out_hit)
      begin
         out_evt.valid <= 1'b1;
         out_evt.index <= cpu_req.addr[7:0];
         out_evt.data  <= cpu_req.wr_data;
      end
   end

endmodule

`default_nettype wire

// ==== hw/m6502_system.sv ====
`default_nettype none

module m6502_system #(
   parameter int ram_addr_bits = 12
) (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                host_wr,
   input  logic [15:0]         host_addr,
   input  logic [7:0]          host_data,
   output m6502_pkg::out_evt_t out_evt
);
   import m6502_pkg::*;

   mem_req_t   cpu_req;
   mem_req_t   ram_req;
   logic [7:0] rd_data;
   logic       ready;

   m6502_cpu i_m6502_cpu (
      .clk     (clk),
      .reset_n (reset_n),
      .mem_req (cpu_req),
      .rd_data (rd_data),
      .ready   (ready)
   );

   m6502_out_port #(.ram_addr_bits(ram_addr_bits)) i_m6502_out_port (
      .clk     (clk),
      .reset_n (reset_n),
      .cpu_req (cpu_req),
      .ram_req (ram_req),
      .out_evt (out_evt)
   );

   m6502_ram #(.ram_addr_bits(ram_addr_bits)) i_m6502_ram (
      .clk       (clk),
      .req       (ram_req),
      .host_wr   (host_wr),
      .host_addr (host_addr),
      .host_data (host_data),
      .rd_data   (rd_data),
      .ready     (ready)
   );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`default_nettype none

module tb_clock #(
   parameter realtime period = 8ns
) (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

endmodule

`default_nettype wire

// ==== verif/m6502_cpu_props.sv ====
`default_nettype none

module m6502_cpu_props (
   input logic                clk,
   input logic                reset_n,
   input m6502_pkg::mem_req_t mem_req,
   input logic                ready
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;
   logic        in_reset_q;  // Reset seen for a full cycle.

   always_ff @(posedge clk)
      in_reset_q <= !reset_n;

   rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
      !(mem_req.rd_req && mem_req.wr_en))
      else
      begin
         $error("rd_req and wr_en high together");
         fail_count++;
      end

   ready_after_rd: assert property (@(posedge clk) disable iff (!reset_n)
      mem_req.rd_req |=> ready)
      else
      begin
         $error("no ready one cycle after rd_req");
         fail_count++;
      end

   quiet_in_reset: assert property (@(posedge clk)
      (!reset_n && in_reset_q) |-> (!mem_req.rd_req && !mem_req.wr_en))
      else
      begin
         $error("bus request while reset_n is low");
         fail_count++;
      end

endmodule

bind m6502_cpu m6502_cpu_props i_m6502_cpu_props (
   .clk     (clk),
   .reset_n (reset_n),
   .mem_req (mem_req),
   .ready   (ready)
);

`default_nettype wire

// ==== verif/tb_m6502_system.sv ====
`default_nettype none

module tb_m6502_system;
   timeunit 1ns;
   timeprecision 100ps;

   import m6502_pkg::*;

   localparam int n_instr          = 21;
   localparam int cycles_per_instr = 12;
   localparam int load_cycles      = 120;
   localparam int watchdog_cycles  = load_cycles + 12 * n_instr * cycles_per_instr;
   localparam int quiet_cycles     = 150;  // Window after the final JMP.
   localparam int n_tests          = 5;

   logic        clk;
   logic        reset_n;
   logic        host_wr;
   logic [15:0] host_addr;
   logic [7:0]  host_data;
   out_evt_t    out_evt;

   logic [7:0]  model_mem [4096];
   int          seed = 32'he2d0_df3e;
   logic [7:0]  exp_index [$];
   logic [7:0]  exp_data [$];
   int          exp_test [$];
   int          got = 0;
   int          test_errors [n_tests];
   string       test_name [n_tests] = '{"reset_imm", "zero_page", "absolute", "indirect",
                                        "ordering"};

   tb_clock #(.period(8ns)) i_tb_clock (.clk(clk));

   m6502_system #(.ram_addr_bits(12)) i_m6502_system (
      .clk       (clk),
      .reset_n   (reset_n),
      .host_wr   (host_wr),
      .host_addr (host_addr),
      .host_data (host_data),
      .out_evt   (out_evt)
   );

   function automatic logic [7:0] rand_byte();
      return 8'($random(seed));
   endfunction

   task automatic host_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge clk);
      host_wr   = 1'b1;
      host_addr = addr;
      host_data = data;
      model_mem[addr[11:0]] = data;
   endtask

   task automatic write_bytes(input logic [15:0] addr, input logic [7:0] b [$]);
      foreach (b[i])
         host_write(addr + 16'(i), b[i]);
   endtask

   task automatic push_expected(input int test, input logic [7:0] index,
                                input logic [7:0] data);
      exp_test.push_back(test);
      exp_index.push_back(index);
      exp_data.push_back(data);
   endtask

   function automatic logic [7:0] mem_at(input logic [15:0] addr);
      return model_mem[addr[11:0]];  // RAM wraps modulo its size.
   endfunction

   // Expected events from the 6502 addressing rules.
   task automatic build_expected(input logic [7:0] v_imm);
      logic [7:0]  xv;
      logic [7:0]  yv;
      logic [7:0]  zp;
      logic [15:0] ptr;
      xv = 8'hf0;
      yv = mem_at(16'h0310);
      push_expected(0, 8'h00, v_imm);
      push_expected(1, 8'h01, mem_at(16'h0005));
      zp = 8'h20 + xv;
      push_expected(1, 8'h02, mem_at({8'h00, zp}));
      push_expected(2, 8'h03, mem_at(16'h0300));
      push_expected(2, 8'h04, mem_at(16'h03f8 + {8'h00, xv}));
      push_expected(2, 8'h05, mem_at(16'h0500 + {8'h00, yv}));
      zp  = 8'h40 + xv;
      ptr = {mem_at({8'h00, 8'(zp + 8'd1)}), mem_at({8'h00, zp})};
      push_expected(3, 8'h06, mem_at(ptr));
      ptr = {mem_at(16'h0051), mem_at(16'h0050)} + {8'h00, yv};
      push_expected(3, 8'h07, mem_at(ptr));
      ptr = {mem_at(16'h0061), mem_at(16'h0060)} + 16'h0020;
      push_expected(3, ptr[7:0], mem_at({mem_at(16'h0051), mem_at(16'h0050)} + {8'h00, yv}));
   endtask

   task automatic report_test(input int t);
      $display("[%s] %s, %0d errors", test_name[t],
               (test_errors[t] == 0) ? "pass" : "FAIL", test_errors[t]);
   endtask

   // Events are sampled on the falling edge.
   always @(negedge clk)
   begin
      if (out_evt.valid)
      begin
         if (!reset_n)
         begin
            $display("Output event seen while reset_n is low");
            test_errors[4]++;
         end
         else if (got >= exp_index.size())
         begin
            $display("Unexpected output event after the program end, index %h", out_evt.index);
            test_errors[4]++;
         end
         else
         begin
            assert (out_evt.index == exp_index[got])
            else
            begin
               $display("Error %s index: expected %h, actual %h", test_name[exp_test[got]],
                        exp_index[got], out_evt.index);
               test_errors[exp_test[got]]++;
            end
            assert (out_evt.data == exp_data[got])
            else
            begin
               $display("Error %s data: expected %h, actual %h", test_name[exp_test[got]],
                        exp_data[got], out_evt.data);
               test_errors[exp_test[got]]++;
            end
            if (got + 1 == exp_index.size() || exp_test[got + 1] != exp_test[got])
               report_test(exp_test[got]);
            got++;
         end
      end
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog expired with %0d of %0d events seen", got, exp_index.size());
      $display("Test failed");
      $finish;
   end

   initial
   begin
      logic [7:0] v_imm;
      int         failed;
      int         total;
      reset_n   = 1'b0;
      host_wr   = 1'b0;
      host_addr = 16'h0000;
      host_data = 8'h00;
      foreach (test_errors[i])
         test_errors[i] = 0;

      v_imm = rand_byte();
      write_bytes(16'hfffc, '{8'h00, 8'h02});
      write_bytes(16'h0200, '{8'ha9, v_imm, 8'h8d, 8'h00, 8'hd0,
                             8'ha5, 8'h05, 8'h8d, 8'h01, 8'hd0,
                             8'ha2, 8'hf0, 8'hb5, 8'h20, 8'h8d, 8'h02, 8'hd0,
                             8'had, 8'h00, 8'h03, 8'h8d, 8'h03, 8'hd0,
                             8'hbd, 8'hf8, 8'h03, 8'h8d, 8'h04, 8'hd0,
                             8'hac, 8'h10, 8'h03, 8'hb9, 8'h00, 8'h05, 8'h8d, 8'h05, 8'hd0,
                             8'ha1, 8'h40, 8'h8d, 8'h06, 8'hd0,
                             8'hb1, 8'h50, 8'h8d, 8'h07, 8'hd0,
                             8'ha0, 8'h20, 8'h91, 8'h60,
                             8'h4c, 8'h34, 8'h02});
      write_bytes(16'h0030, '{8'h00, 8'h06});
      write_bytes(16'h0050, '{8'h00, 8'h07});
      write_bytes(16'h0060, '{8'h10, 8'hd0});
      host_write(16'h0005, rand_byte());
      host_write(16'h0010, rand_byte());
      host_write(16'h0300, rand_byte());
      host_write(16'h04e8, rand_byte());
      host_write(16'h0310, rand_byte());
      host_write(16'h0500 + {8'h00, model_mem[12'h310]}, rand_byte());
      host_write(16'h0600, rand_byte());
      host_write(16'h0700 + {8'h00, model_mem[12'h310]}, rand_byte());
      build_expected(v_imm);

      @(negedge clk);
      host_wr = 1'b0;
      repeat (16) @(negedge clk);
      reset_n = 1'b1;

      wait (got == exp_index.size());
      repeat (quiet_cycles) @(negedge clk);
      report_test(4);

      failed = 0;
      total  = i_m6502_system.i_m6502_cpu.i_m6502_cpu_props.fail_count;
      foreach (test_errors[i])
      begin
         total += test_errors[i];
         if (test_errors[i] != 0)
            failed++;
      end
      $display("Tests: %0d run, %0d failed, %0d check errors", n_tests, failed, total);
      if (total == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/m6502_pkg.sv
hw/m6502_decode.sv
hw/m6502_agu.sv
hw/m6502_cpu.sv
hw/m6502_ram.sv
hw/m6502_out_port.sv
hw/m6502_system.sv
verif/tb_clock.sv
verif/m6502_cpu_props.sv
verif/tb_m6502_system.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_m6502_system -f filelist.f

out=$(./obj_dir/Vtb_m6502_system +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -qx "Test passed"
